// File: Bender.yml
package:
  name: hough_lane

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/hough_lane_pkg.sv
      - hw/pixel_fifo.sv
      - hw/edge_loader.sv
      - hw/hough_voter.sv
      - hw/peak_finder.sv
      - hw/hough_lane_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/hough_lane_assert.sv
      - tests/tb_hough_lane.sv

// File: filelist.f
+incdir+hw
hw/hough_lane_pkg.sv
hw/pixel_fifo.sv
hw/edge_loader.sv
hw/hough_voter.sv
hw/peak_finder.sv
hw/hough_lane_top.sv
tests/hough_lane_assert.sv
tests/tb_hough_lane.sv

// File: hw/edge_loader.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module edge_loader (
    input  logic                     clock,
    input  logic                     arst_n,
    output logic                     fifo_rd_en,
    input  logic                     fifo_empty,
    input  hough_lane_pkg::rgb_t     fifo_dout,
    output logic                     frame_loaded,
    input  logic                     hough_done,
    input  hough_lane_pkg::pix_addr_t edge_rd_addr,
    output logic                     edge_rd_bit
);

    hough_lane_pkg::loader_state_e state;

    // Reads issued for the current frame
    logic [8:0] rd_count;

    logic                      rd_valid_q;
    logic                      edge_valid_q;
    logic                      edge_q;
    hough_lane_pkg::pix_addr_t wr_addr;

    logic [15:0]           luma_sum;
    hough_lane_pkg::gray_t gray;

    // One bit per pixel, raster order
    logic [`HL_PIXELS-1:0] edge_map;

    assign fifo_rd_en = (state == hough_lane_pkg::LS_LOAD) && !fifo_empty
                        && (rd_count != 9'(`HL_PIXELS));

    // Integer luma weights summing to 256
    assign luma_sum = 16'(77 * fifo_dout[23:16] + 150 * fifo_dout[15:8] + 29 * fifo_dout[7:0]);
    assign gray     = luma_sum[15:8];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= hough_lane_pkg::LS_LOAD;
            rd_count     <= '0;
            rd_valid_q   <= 1'b0;
            edge_valid_q <= 1'b0;
            wr_addr      <= '0;
            frame_loaded <= 1'b0;
        end else begin
            rd_valid_q   <= fifo_rd_en;
            edge_valid_q <= rd_valid_q;
            frame_loaded <= 1'b0;
            if (fifo_rd_en) begin
                rd_count <= rd_count + 1'b1;
            end
            if (edge_valid_q) begin
                // Address wraps back to zero after the last pixel
                wr_addr <= wr_addr + 1'b1;
                if (wr_addr == hough_lane_pkg::pix_addr_t'(`HL_PIXELS - 1)) begin
                    frame_loaded <= 1'b1;
                    state        <= hough_lane_pkg::LS_WAIT_HOUGH;
                end
            end
            // Map stays frozen until the peak is out
            if (state == hough_lane_pkg::LS_WAIT_HOUGH && hough_done) begin
                state    <= hough_lane_pkg::LS_LOAD;
                rd_count <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        edge_q <= (gray >= `HL_EDGE_THRESH);
        if (edge_valid_q) begin
            edge_map[wr_addr] <= edge_q;
        end
        edge_rd_bit <= edge_map[edge_rd_addr];
    end

endmodule

// File: hw/hough_lane_config.svh
`ifndef HOUGH_LANE_CONFIG_SVH
`define HOUGH_LANE_CONFIG_SVH

// Frame geometry
`define HL_IMG_W 16
`define HL_IMG_H 16
`define HL_PIXELS (`HL_IMG_W * `HL_IMG_H)

// Hough space
`define HL_THETAS 4
`define HL_RHO_BINS 64

// Added to rho so that negative rho lands on a valid bin
`define HL_RHO_OFFSET 16

// Gray level at or above which a pixel counts as an edge
`define HL_EDGE_THRESH 128

// Input buffering between the pixel source and the loader
`define HL_FIFO_DEPTH 16

`endif

// File: hw/hough_lane_pkg.sv
`include "hough_lane_config.svh"

package hough_lane_pkg;

    // Pixel and address types
    typedef logic [23:0] rgb_t;
    typedef logic [7:0] gray_t;
    typedef logic [$clog2(`HL_PIXELS)-1:0] pix_addr_t;
    typedef logic [3:0] coord_t;

    // Hough space types
    typedef logic [1:0] theta_t;
    typedef logic [5:0] rho_t;
    typedef logic [8:0] vote_t;
    typedef logic [7:0] acc_addr_t;

    // Read request into the accumulator, address is {theta, rho bin}
    typedef struct packed {
        logic      valid;
        acc_addr_t addr;
    } acc_port_s;

    // Strongest line of a frame
    typedef struct packed {
        theta_t theta;
        rho_t   rho;
        vote_t  votes;
    } lane_peak_s;

    typedef enum logic [0:0] {LS_LOAD, LS_WAIT_HOUGH} loader_state_e;

    typedef enum logic [2:0] {VS_IDLE, VS_CLEAR, VS_FETCH, VS_VOTE, VS_DONE} voter_state_e;

    typedef enum logic [1:0] {PS_IDLE, PS_SCAN, PS_PUBLISH} peak_state_e;

    // Q7 cosine and sine for 0, 45, 90 and 135 degrees
    localparam logic signed [8:0] cos_q7 [0:`HL_THETAS-1] = '{
        9'sd128, 9'sd91, 9'sd0, -9'sd91
    };
    localparam logic signed [8:0] sin_q7 [0:`HL_THETAS-1] = '{
        9'sd0, 9'sd91, 9'sd128, 9'sd91
    };

endpackage

// File: hw/hough_lane_top.sv
`timescale 1ns/1ps

module hough_lane_top (
    input  logic                       clock,
    input  logic                       arst_n,
    // Pixel input
    input  logic                       pixel_wr_en,
    input  hough_lane_pkg::rgb_t       pixel_din,
    output logic                       pixel_full,
    // Result
    output logic                       hough_done,
    output hough_lane_pkg::lane_peak_s lane_peak
);

    // FIFO to loader
    hough_lane_pkg::rgb_t      fifo_dout;
    logic                      fifo_empty;
    logic                      fifo_rd_en;

    // Loader to voter
    logic                      frame_loaded;
    hough_lane_pkg::pix_addr_t edge_rd_addr;
    logic                      edge_rd_bit;

    // Voter to peak finder
    logic                      vote_done;
    hough_lane_pkg::acc_port_s acc_rd;
    hough_lane_pkg::vote_t     acc_rd_votes;

    pixel_fifo pixel_fifo_inst (
        .clock (clock),
        .arst_n(arst_n),
        .wr_en (pixel_wr_en),
        .din   (pixel_din),
        .full  (pixel_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    edge_loader edge_loader_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .fifo_rd_en  (fifo_rd_en),
        .fifo_empty  (fifo_empty),
        .fifo_dout   (fifo_dout),
        .frame_loaded(frame_loaded),
        .hough_done  (hough_done),
        .edge_rd_addr(edge_rd_addr),
        .edge_rd_bit (edge_rd_bit)
    );

    hough_voter hough_voter_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .frame_loaded(frame_loaded),
        .edge_rd_addr(edge_rd_addr),
        .edge_rd_bit (edge_rd_bit),
        .vote_done   (vote_done),
        .acc_rd      (acc_rd),
        .acc_rd_votes(acc_rd_votes)
    );

    peak_finder peak_finder_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .vote_done   (vote_done),
        .acc_rd      (acc_rd),
        .acc_rd_votes(acc_rd_votes),
        .hough_done  (hough_done),
        .lane_peak   (lane_peak)
    );

endmodule

// File: hw/hough_voter.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module hough_voter (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       frame_loaded,
    output hough_lane_pkg::pix_addr_t  edge_rd_addr,
    input  logic                       edge_rd_bit,
    output logic                       vote_done,
    input  hough_lane_pkg::acc_port_s  acc_rd,
    output hough_lane_pkg::vote_t      acc_rd_votes
);

    localparam int ACC_DEPTH = `HL_THETAS * `HL_RHO_BINS;

    hough_lane_pkg::vote_t acc [0:ACC_DEPTH-1];

    hough_lane_pkg::voter_state_e state;

    // Low on the address cycle, high on the data cycle
    logic                        phase;
    hough_lane_pkg::theta_t      theta;
    hough_lane_pkg::pix_addr_t   pix_addr;
    hough_lane_pkg::acc_addr_t   clr_addr;

    hough_lane_pkg::coord_t      x;
    hough_lane_pkg::coord_t      y;
    logic signed [13:0]          rho_sum;
    hough_lane_pkg::rho_t        rho_bin;
    hough_lane_pkg::acc_addr_t   vote_addr;
    hough_lane_pkg::vote_t       acc_q;

    logic                        acc_we;
    hough_lane_pkg::acc_addr_t   acc_wa;
    hough_lane_pkg::vote_t       acc_wd;

    logic last_pixel;

    assign edge_rd_addr = pix_addr;
    assign vote_done    = (state == hough_lane_pkg::VS_DONE);

    assign x = hough_lane_pkg::coord_t'(pix_addr % `HL_IMG_W);
    assign y = hough_lane_pkg::coord_t'(pix_addr / `HL_IMG_W);

    // rho = floor((x*cos + y*sin) / 128), then shifted into bin range
    assign rho_sum = $signed({1'b0, x}) * hough_lane_pkg::cos_q7[theta]
                   + $signed({1'b0, y}) * hough_lane_pkg::sin_q7[theta];
    assign rho_bin   = hough_lane_pkg::rho_t'((rho_sum >>> 7) + `HL_RHO_OFFSET);
    assign vote_addr = {theta, rho_bin};

    // Single write port shared by clearing and voting
    assign acc_we = (state == hough_lane_pkg::VS_CLEAR)
                    || (state == hough_lane_pkg::VS_VOTE && phase);
    assign acc_wa = (state == hough_lane_pkg::VS_CLEAR) ? clr_addr : vote_addr;
    assign acc_wd = (state == hough_lane_pkg::VS_CLEAR) ? '0 : acc_q + 1'b1;

    assign last_pixel = (pix_addr == hough_lane_pkg::pix_addr_t'(`HL_PIXELS - 1));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= hough_lane_pkg::VS_IDLE;
            phase    <= 1'b0;
            theta    <= '0;
            pix_addr <= '0;
            clr_addr <= '0;
        end else begin
            case (state)
                hough_lane_pkg::VS_IDLE: begin
                    if (frame_loaded) begin
                        state    <= hough_lane_pkg::VS_CLEAR;
                        clr_addr <= '0;
                    end
                end
                hough_lane_pkg::VS_CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == hough_lane_pkg::acc_addr_t'(ACC_DEPTH - 1)) begin
                        state    <= hough_lane_pkg::VS_FETCH;
                        pix_addr <= '0;
                        phase    <= 1'b0;
                    end
                end
                hough_lane_pkg::VS_FETCH: begin
                    phase <= !phase;
                    if (phase) begin
                        if (edge_rd_bit) begin
                            state <= hough_lane_pkg::VS_VOTE;
                            theta <= '0;
                        end else if (last_pixel) begin
                            state <= hough_lane_pkg::VS_DONE;
                        end else begin
                            pix_addr <= pix_addr + 1'b1;
                        end
                    end
                end
                hough_lane_pkg::VS_VOTE: begin
                    // Read on phase 0, write back the increment on phase 1
                    phase <= !phase;
                    if (phase) begin
                        if (theta != hough_lane_pkg::theta_t'(`HL_THETAS - 1)) begin
                            theta <= theta + 1'b1;
                        end else if (last_pixel) begin
                            state <= hough_lane_pkg::VS_DONE;
                        end else begin
                            state    <= hough_lane_pkg::VS_FETCH;
                            pix_addr <= pix_addr + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= hough_lane_pkg::VS_IDLE;
                end
            endcase
        end
    end

    // Accumulator memory, second read port serves the peak finder
    always_ff @(posedge clock) begin
        if (acc_we) begin
            acc[acc_wa] <= acc_wd;
        end
        acc_q <= acc[vote_addr];
        if (acc_rd.valid) begin
            acc_rd_votes <= acc[acc_rd.addr];
        end
    end

endmodule

// File: hw/peak_finder.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module peak_finder (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       vote_done,
    output hough_lane_pkg::acc_port_s  acc_rd,
    input  hough_lane_pkg::vote_t      acc_rd_votes,
    output logic                       hough_done,
    output hough_lane_pkg::lane_peak_s lane_peak
);

    localparam int ACC_DEPTH = `HL_THETAS * `HL_RHO_BINS;

    hough_lane_pkg::peak_state_e state;
    hough_lane_pkg::acc_addr_t   scan_addr;

    // Address of the bin whose votes arrive this cycle
    logic                       rd_pending;
    hough_lane_pkg::acc_addr_t  rd_addr_q;

    hough_lane_pkg::lane_peak_s best;
    hough_lane_pkg::lane_peak_s next_best;
    logic                       better;

    assign acc_rd = '{valid: (state == hough_lane_pkg::PS_SCAN), addr: scan_addr};

    // Strictly greater only, so ties keep the earlier bin
    assign better    = rd_pending && (acc_rd_votes > best.votes);
    assign next_best = better ? '{theta: hough_lane_pkg::theta_t'(rd_addr_q >> 6),
                                  rho:   hough_lane_pkg::rho_t'(rd_addr_q),
                                  votes: acc_rd_votes}
                              : best;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state      <= hough_lane_pkg::PS_IDLE;
            scan_addr  <= '0;
            rd_pending <= 1'b0;
            best       <= '0;
            lane_peak  <= '0;
            hough_done <= 1'b0;
        end else begin
            rd_pending <= acc_rd.valid;
            hough_done <= (state == hough_lane_pkg::PS_PUBLISH);
            case (state)
                hough_lane_pkg::PS_IDLE: begin
                    if (vote_done) begin
                        state     <= hough_lane_pkg::PS_SCAN;
                        scan_addr <= '0;
                        // Start at theta 0, rho 0 so an empty frame reports that line
                        best      <= '{theta: '0,
                                       rho: hough_lane_pkg::rho_t'(`HL_RHO_OFFSET),
                                       votes: '0};
                    end
                end
                hough_lane_pkg::PS_SCAN: begin
                    best      <= next_best;
                    scan_addr <= scan_addr + 1'b1;
                    if (scan_addr == hough_lane_pkg::acc_addr_t'(ACC_DEPTH - 1)) begin
                        state <= hough_lane_pkg::PS_PUBLISH;
                    end
                end
                default: begin
                    // Last bin is still in flight here
                    best      <= next_best;
                    lane_peak <= next_best;
                    state     <= hough_lane_pkg::PS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        rd_addr_q <= scan_addr;
    end

endmodule

// File: hw/pixel_fifo.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module pixel_fifo (
    input  logic                clock,
    input  logic                arst_n,
    input  logic                wr_en,
    input  hough_lane_pkg::rgb_t din,
    output logic                full,
    input  logic                rd_en,
    output hough_lane_pkg::rgb_t dout,
    output logic                empty
);

    localparam int AW = $clog2(`HL_FIFO_DEPTH);

    hough_lane_pkg::rgb_t mem [0:`HL_FIFO_DEPTH-1];

    // Extra top bit tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage and read data
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr[AW-1:0]];
        end
    end

endmodule

// File: tests/hough_lane_assert.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module hough_lane_assert (
    input logic                       clock,
    input logic                       arst_n,
    input logic                       pixel_wr_en,
    input logic                       pixel_full,
    input logic                       hough_done,
    input hough_lane_pkg::lane_peak_s lane_peak
);

    // Result pulse lasts a single cycle
    single_done_pulse: assert property (
        @(posedge clock) disable iff (!arst_n) hough_done |=> !hough_done
    ) else $error("hough_done stayed high for two cycles");

    // No bin collects more votes than a frame has pixels
    votes_in_range: assert property (
        @(posedge clock) disable iff (!arst_n) lane_peak.votes <= 9'(`HL_PIXELS)
    ) else $error("lane_peak votes above the pixel count");

    // A write is only offered while the FIFO has room
    no_write_when_full: assert property (
        @(posedge clock) disable iff (!arst_n) !(pixel_full && pixel_wr_en)
    ) else $error("pixel write offered while pixel_full is high");

endmodule

bind hough_lane_top hough_lane_assert hough_lane_assert_inst (
    .clock      (clock),
    .arst_n     (arst_n),
    .pixel_wr_en(pixel_wr_en),
    .pixel_full (pixel_full),
    .hough_done (hough_done),
    .lane_peak  (lane_peak)
);

// File: tests/tb_hough_lane.sv
`timescale 1ns/1ps
`include "hough_lane_config.svh"

module tb_hough_lane;

    // Eight frames in total, each well inside this many cycles
    localparam int FRAME_CYCLES   = 2400;
    localparam int FRAME_COUNT    = 8;
    localparam int TIMEOUT_CYCLES = FRAME_COUNT * FRAME_CYCLES;

    logic                       clock;
    logic                       arst_n;
    logic                       pixel_wr_en;
    hough_lane_pkg::rgb_t       pixel_din;
    logic                       pixel_full;
    logic                       hough_done;
    hough_lane_pkg::lane_peak_s lane_peak;

    hough_lane_pkg::rgb_t       frame_buf [0:`HL_PIXELS-1];
    hough_lane_pkg::lane_peak_s result_q [$];

    integer seed = 32'he98b2864;
    int     cycle_count;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     errors_at_start;
    logic   full_seen;

    hough_lane_top hough_lane_top_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .pixel_wr_en(pixel_wr_en),
        .pixel_din  (pixel_din),
        .pixel_full (pixel_full),
        .hough_done (hough_done),
        .lane_peak  (lane_peak)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Results are captured on the falling edge, half a cycle after they change
    always @(negedge clock) begin
        if (arst_n && hough_done) begin
            result_q.push_back(lane_peak);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: no finish after %0d clock cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int gray_of(input hough_lane_pkg::rgb_t pix);
        int sum;
        sum = 77 * pix[23:16] + 150 * pix[15:8] + 29 * pix[7:0];
        return sum >> 8;
    endfunction

    function automatic hough_lane_pkg::lane_peak_s make_peak(input int theta, input int rho,
                                                             input int votes);
        hough_lane_pkg::lane_peak_s peak;
        peak.theta = hough_lane_pkg::theta_t'(theta);
        peak.rho   = hough_lane_pkg::rho_t'(rho);
        peak.votes = hough_lane_pkg::vote_t'(votes);
        return peak;
    endfunction

    // Model of the whole frame: threshold, vote, then first strict maximum
    task automatic reference_peak(output hough_lane_pkg::lane_peak_s peak);
        int acc [0:`HL_THETAS*`HL_RHO_BINS-1];
        int x;
        int y;
        int rho;
        int best;
        foreach (acc[i]) begin
            acc[i] = 0;
        end
        for (int p = 0; p < `HL_PIXELS; p++) begin
            x = p % `HL_IMG_W;
            y = p / `HL_IMG_W;
            if (gray_of(frame_buf[p]) >= `HL_EDGE_THRESH) begin
                for (int t = 0; t < `HL_THETAS; t++) begin
                    rho = (x * hough_lane_pkg::cos_q7[t] + y * hough_lane_pkg::sin_q7[t]) >>> 7;
                    acc[t * `HL_RHO_BINS + rho + `HL_RHO_OFFSET]++;
                end
            end
        end
        best = 0;
        peak = make_peak(0, `HL_RHO_OFFSET, 0);
        for (int t = 0; t < `HL_THETAS; t++) begin
            for (int r = 0; r < `HL_RHO_BINS; r++) begin
                if (acc[t * `HL_RHO_BINS + r] > best) begin
                    best = acc[t * `HL_RHO_BINS + r];
                    peak = make_peak(t, r, best);
                end
            end
        end
    endtask

    task automatic fill_frame(input hough_lane_pkg::rgb_t value);
        foreach (frame_buf[p]) begin
            frame_buf[p] = value;
        end
    endtask

    task automatic fill_random();
        logic [31:0] raw;
        for (int p = 0; p < `HL_PIXELS; p++) begin
            raw = $random(seed);
            // Most pixels stay dark so that equal bins show up now and then
            if (raw[31:30] != 2'b00) begin
                frame_buf[p] = raw[23:0] & 24'h7f7f7f;
            end else begin
                frame_buf[p] = raw[23:0];
            end
        end
    endtask

    task automatic send_frame();
        int idx;
        idx = 0;
        while (idx < `HL_PIXELS) begin
            @(negedge clock);
            if (!pixel_full) begin
                pixel_wr_en = 1'b1;
                pixel_din   = frame_buf[idx];
                idx++;
            end else begin
                pixel_wr_en = 1'b0;
                full_seen   = 1'b1;
            end
        end
        @(negedge clock);
        pixel_wr_en = 1'b0;
    endtask

    task automatic take_result(output hough_lane_pkg::lane_peak_s peak);
        while (result_q.size() == 0) begin
            @(negedge clock);
        end
        peak = result_q.pop_front();
    endtask

    task automatic check_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_peak(input string test_name, input hough_lane_pkg::lane_peak_s expected,
                              input hough_lane_pkg::lane_peak_s actual);
        check_value(test_name, "theta", expected.theta, actual.theta);
        check_value(test_name, "rho", expected.rho, actual.rho);
        check_value(test_name, "votes", expected.votes, actual.votes);
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic end_test(input string test_name);
        if (error_count == errors_at_start) begin
            $display("test %s passed", test_name);
        end else begin
            failed_tests++;
            $display("test %s failed with %0d mismatches", test_name,
                     error_count - errors_at_start);
        end
    endtask

    task automatic reset_state_test();
        begin_test();
        check_value("reset_state", "hough_done", 1'b0, hough_done);
        check_value("reset_state", "pixel_full", 1'b0, pixel_full);
        check_value("reset_state", "lane_peak", '0, lane_peak);
        end_test("reset_state");
    endtask

    task automatic vertical_line_test();
        hough_lane_pkg::lane_peak_s got;
        begin_test();
        fill_frame(24'h000000);
        for (int y = 0; y < `HL_IMG_H; y++) begin
            frame_buf[y * `HL_IMG_W + 5] = 24'hffffff;
        end
        send_frame();
        take_result(got);
        check_peak("vertical_line", make_peak(0, 21, 16), got);
        end_test("vertical_line");
    endtask

    task automatic diagonal_line_test();
        hough_lane_pkg::lane_peak_s got;
        begin_test();
        fill_frame(24'h000000);
        for (int i = 0; i < `HL_IMG_W; i++) begin
            frame_buf[i * `HL_IMG_W + i] = 24'hffffff;
        end
        // Gray 127 and gray 128 on either side of the threshold
        frame_buf[10] = 24'h7f7f7f;
        frame_buf[12] = 24'h808080;
        send_frame();
        take_result(got);
        check_peak("diagonal_line", make_peak(3, 16, 16), got);
        check_value("diagonal_line", "edge at gray 127", 1'b0,
                    hough_lane_top_inst.edge_loader_inst.edge_map[10]);
        check_value("diagonal_line", "edge at gray 128", 1'b1,
                    hough_lane_top_inst.edge_loader_inst.edge_map[12]);
        end_test("diagonal_line");
    endtask

    task automatic empty_frame_test();
        hough_lane_pkg::lane_peak_s got;
        begin_test();
        fill_frame(24'h000000);
        send_frame();
        take_result(got);
        check_peak("empty_frame", make_peak(0, 16, 0), got);
        end_test("empty_frame");
    endtask

    task automatic random_frames_test();
        hough_lane_pkg::lane_peak_s expected;
        hough_lane_pkg::lane_peak_s got;
        begin_test();
        for (int f = 0; f < 3; f++) begin
            fill_random();
            reference_peak(expected);
            send_frame();
            take_result(got);
            check_peak($sformatf("random_frame_%0d", f), expected, got);
        end
        end_test("random_frames");
    endtask

    task automatic back_pressure_test();
        hough_lane_pkg::lane_peak_s expected_a;
        hough_lane_pkg::lane_peak_s expected_b;
        hough_lane_pkg::lane_peak_s got;
        begin_test();
        full_seen = 1'b0;
        fill_random();
        reference_peak(expected_a);
        send_frame();
        // Second frame goes in while the first one is still being voted
        fill_frame(24'h000000);
        for (int y = 0; y < `HL_IMG_H; y++) begin
            frame_buf[y * `HL_IMG_W + 9] = 24'hc0c0c0;
        end
        reference_peak(expected_b);
        send_frame();
        take_result(got);
        check_peak("back_pressure first", expected_a, got);
        take_result(got);
        check_peak("back_pressure second", expected_b, got);
        check_value("back_pressure", "pixel_full seen", 1'b1, full_seen);
        end_test("back_pressure");
    endtask

    initial begin
        arst_n       = 1'b0;
        pixel_wr_en  = 1'b0;
        pixel_din    = '0;
        full_seen    = 1'b0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        repeat (8) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);

        reset_state_test();
        vertical_line_test();
        diagonal_line_test();
        empty_frame_test();
        random_frames_test();
        back_pressure_test();

        repeat (4) @(negedge clock);
        if (result_q.size() != 0) begin
            $display("Error: %0d results arrived that no test asked for", result_q.size());
            error_count++;
        end
        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
